// File: run.sh
#!/bin/sh
# compile and run the controlUnit testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module controlUnitTb -f vlog.f
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/VcontrolUnitTb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
exit 0

// File: verification/controlUnitTb.sv
module controlUnitTb;
    timeunit 1ns;
    timeprecision 100ps;
    import isaPkg::*;
    import ctrlPkg::*;

    localparam regIdx_t SpLowReg   = 4'd12;
    localparam int      NumAlu     = 40;
    localparam int      NumIo      = 20;
    localparam int      NumPair    = 30;
    localparam int      NumJump    = 30;
    localparam int      NumCall    = 30;
    localparam int      NumHalt    = 3;  // each halt is followed by a NOP
    localparam int      HaltHold   = 6;
    localparam int      TotalWords = NumAlu + NumIo + NumPair + NumJump + NumCall + 2 * NumHalt;
    localparam int      CycleLimit = TotalWords * 3 + 50;

    typedef struct packed {
        regCtrl_t   rc;
        aluCtrl_t   ac;
        memCtrl_t   mc;
        fetchCtrl_t fc;
        step_t      next;  // model step after this cycle
    } ctrlWord_t;

    logic        clk = 1'b0;
    logic        rstN;
    instr_t      instr;
    flags_t      flags;
    regCtrl_t    regCtrl;
    aluCtrl_t    aluCtrl;
    memCtrl_t    memCtrl;
    fetchCtrl_t  fetchCtrl;
    ctrlWord_t   expWord;
    step_t       modelStep;
    logic [31:0] rngState = 32'd27;
    int          driveCount = 0;
    int          seenCount = 0;
    int          checkCount = 0;
    int          errorCount = 0;
    int          cycleCount = 0;

    always #50 clk = ~clk;

    controlUnit #(
        .SpLowReg(SpLowReg)
    ) dut_i (
        .clk      (clk),
        .rstN     (rstN),
        .instr    (instr),
        .flags    (flags),
        .regCtrl  (regCtrl),
        .aluCtrl  (aluCtrl),
        .memCtrl  (memCtrl),
        .fetchCtrl(fetchCtrl)
    );

    function automatic logic [31:0] nextRand();
        logic [31:0] x;
        x = rngState;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rngState = x;
        return x;
    endfunction

    // expected control word for one cycle of word w at model step s
    function automatic ctrlWord_t refControl(input instr_t w, input flags_t f, input step_t s);
        ctrlWord_t  e;
        logic [4:0] op;
        logic       go;
        logic       late;
        regIdx_t    pair;
        op   = w[7:3];
        late = (s == stepDataWait);
        pair = {w[11:9], 1'b0};
        case (w[15:13])
            3'd1:    go = f.carry;
            3'd2:    go = !f.carry;
            3'd3:    go = f.zero;
            3'd4:    go = !f.zero;
            3'd5:    go = f.negative;
            3'd6:    go = !f.negative;
            default: go = 1'b1;
        endcase
        e.rc   = '{regSrcAlu, w[15:12], 1'b0, 1'b0, 1'b0};  // NOP word
        e.ac   = '{aluBReg, aluPassB};
        e.mc   = '{dataAlu, addrPair, 1'b0, 1'b0};
        e.fc   = '{fetchPcOut, 1'b1, 1'b1, 1'b0};
        e.next = stepExec;
        if (w[0] && w[3:1] != 3'b111) begin
            e.rc.writeEn    = 1'b1;
            e.ac.bSel       = aluBImm;
            e.ac.mode       = {1'b0, w[3:1]};
            e.fc.flagEnable = (w[3:1] != 3'b000);  // LDI leaves flags alone
        end else if (w[2:0] == 3'b010 || w[2:0] == 3'b100) begin
            e.mc.addrSel = addrPort;
            if (w[1]) begin
                e.rc.src       = regSrcMem;
                e.rc.writeEn   = late;
                e.mc.readEn    = 1'b1;
                e.fc.readEn    = late;
                e.fc.pcWriteEn = late;
                e.next         = late ? stepExec : stepDataWait;
            end else begin
                e.mc.writeEn = 1'b1;
            end
        end else if (w[2:0] == 3'b000) begin
            if (op >= 5'h01 && op <= 5'h0C) begin
                e.rc.outBSel    = w[11:8];
                e.rc.writeEn    = 1'b1;
                e.ac.mode       = w[6:3];
                e.fc.flagEnable = 1'b1;
            end else if (op >= opStore && op <= opLoadDec) begin
                e.rc.outBSel = pair;
                e.ac.mode    = aluPassA;
                if (op <= opStoreDec) begin
                    e.rc.incPair = (op == opStoreInc);
                    e.rc.decPair = (op == opStoreDec);
                    e.mc.writeEn = 1'b1;
                end else begin
                    e.rc.src       = regSrcMem;
                    e.rc.writeEn   = late;
                    e.rc.incPair   = (op == opLoadInc) && late;
                    e.rc.decPair   = (op == opLoadDec) && late;
                    e.mc.readEn    = 1'b1;
                    e.fc.readEn    = late;
                    e.fc.pcWriteEn = late;
                    e.next         = late ? stepExec : stepDataWait;
                end
            end else if (op == opPairInc || op == opPairDec || op == opJumpInd) begin
                e.rc.outBSel = pair;
                e.rc.incPair = (op == opPairInc);
                e.rc.decPair = (op == opPairDec);
                if (op == opJumpInd && go)
                    e.fc.addrSel = fetchPair;
            end else if (op == opJmp) begin
                if (s == stepJumpTarget)
                    e.fc.addrSel = fetchIMem;
                else if (go)
                    e.next = stepJumpTarget;
                else
                    e.fc.addrSel = fetchPcPlusOne;  // step over the target word
            end else if (op == opCall) begin
                e.rc.outBSel = SpLowReg;
                if (s == stepCallHigh) begin
                    e.rc.decPair  = 1'b1;
                    e.mc.dataSel  = dataPcHigh;
                    e.mc.writeEn  = 1'b1;
                    e.fc.addrSel  = fetchIMem;
                end else if (go) begin
                    e.rc.decPair   = 1'b1;
                    e.mc.dataSel   = dataPcLow;
                    e.mc.writeEn   = 1'b1;
                    e.fc.pcWriteEn = 1'b0;
                    e.next         = stepCallHigh;
                end else begin
                    e.fc.addrSel = fetchPcPlusOne;
                end
            end else if (op == opRet) begin
                e.rc.outBSel = SpLowReg;
                e.mc.addrSel = addrStackPlusOne;
                if (s == stepRetLoad) begin
                    e.mc.readEn  = 1'b1;
                    e.fc.addrSel = fetchRetAddr;
                end else if (s == stepRetPop || go) begin
                    e.rc.incPair   = 1'b1;
                    e.mc.readEn    = 1'b1;
                    e.fc.addrSel   = fetchRetAddr;
                    e.fc.readEn    = 1'b0;
                    e.fc.pcWriteEn = 1'b0;
                    e.next         = (s == stepRetPop) ? stepRetLoad : stepRetPop;
                end
            end else if (op == opHlt) begin
                e.fc.readEn    = 1'b0;
                e.fc.pcWriteEn = 1'b0;
            end
        end
        return e;
    endfunction

    task automatic checkReg(input regCtrl_t got, input regCtrl_t exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("[ERROR] regCtrl instr %h: got %h, expected %h", instr, got, exp);
        end
    endtask

    task automatic checkAlu(input aluCtrl_t got, input aluCtrl_t exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("[ERROR] aluCtrl instr %h: got %h, expected %h", instr, got, exp);
        end
    endtask

    task automatic checkMem(input memCtrl_t got, input memCtrl_t exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("[ERROR] memCtrl instr %h: got %h, expected %h", instr, got, exp);
        end
    endtask

    task automatic checkFetch(input fetchCtrl_t got, input fetchCtrl_t exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("[ERROR] fetchCtrl instr %h: got %h, expected %h", instr, got, exp);
        end
    endtask

    always @(negedge clk) begin
        #25;  // words driven on this edge have settled
        if (driveCount != seenCount) begin
            seenCount = driveCount;
            checkReg(regCtrl, expWord.rc);
            checkAlu(aluCtrl, expWord.ac);
            checkMem(memCtrl, expWord.mc);
            checkFetch(fetchCtrl, expWord.fc);
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > CycleLimit) begin
            $display("timeout after %0d cycles, the tests did not finish", cycleCount);
            $display("TEST FAILED");
            $finish;
        end
    end

    // holds a word until the model step is back at stepExec
    task automatic applyWord(input instr_t w, input int minCycles);
        int          n;
        logic [31:0] r;
        n = 0;
        do begin
            @(negedge clk);
            r         = nextRand();
            instr     = w;
            flags     = r[2:0];
            expWord   = refControl(w, flags, modelStep);
            modelStep = expWord.next;
            driveCount++;
            n++;
        end while (n < minCycles || modelStep != stepExec);
    endtask

    task automatic runTest(input int kind, input string name, input int count);
        int          startErrors;
        logic [31:0] r;
        instr_t      w;
        startErrors = errorCount;
        for (int i = 0; i < count; i++) begin
            r = nextRand();
            case (kind)
                1: begin
                    if (r[16])
                        w = {r[15:4], r[19:17] % 3'd7, 1'b1};
                    else
                        w = {r[15:8], 5'd1 + {1'b0, r[23:20] % 4'd12}, 3'b000};
                end
                2: w = {r[15:3], r[16] ? 3'b010 : 3'b100};
                3: w = {r[15:8], 5'h0D + {2'b00, r[18:16]}, 3'b000};
                4: w = {r[15:8], r[16] ? opJmp : opJumpInd, 3'b000};
                5: w = {r[15:8], r[16] ? opCall : opRet, 3'b000};
                default: w = {r[15:8], opHlt, 3'b000};
            endcase
            applyWord(w, (kind == 6) ? HaltHold : 1);
            if (kind == 6)
                applyWord(16'h0000, 1);  // NOP releases the halt
        end
        @(posedge clk);  // after the last compare
        $display("test %0d %s: %0d words, %0d errors", kind, name, count,
                 errorCount - startErrors);
    endtask

    initial begin
        rstN      = 1'b0;
        instr     = 16'h0000;  // NOP during reset
        flags     = 3'b000;
        modelStep = stepExec;
        expWord   = '0;
        repeat (5) @(negedge clk);
        rstN = 1'b1;
        runTest(1, "alu immediate and register", NumAlu);
        runTest(2, "in and out", NumIo);
        runTest(3, "pair store, load, inc, dec", NumPair);
        runTest(4, "jmp and indirect jump", NumJump);
        runTest(5, "call and ret", NumCall);
        runTest(6, "halt then nop", NumHalt);
        $display("%0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

// File: verification/controlUnit_checker.sv
module controlUnit_checker (
    input logic              clk,
    input logic              rstN,
    input ctrlPkg::regCtrl_t regCtrl,
    input ctrlPkg::memCtrl_t memCtrl,
    input ctrlPkg::step_t    step
);
    timeunit 1ns;
    timeprecision 100ps;
    import ctrlPkg::*;

    // a pair moves one way per cycle
    assert property (@(posedge clk) disable iff (!rstN)
        !(regCtrl.incPair && regCtrl.decPair))
        else $error("pair increment and decrement both high");

    assert property (@(posedge clk) disable iff (!rstN)
        !(memCtrl.readEn && memCtrl.writeEn))
        else $error("memory read and write enable both high");

    // ret is the longest sequence, two steps away from stepExec
    // halt stays in stepExec so it never trips this
    assert property (@(posedge clk) disable iff (!rstN)
        !(step != stepExec && $past(step) != stepExec && $past(step, 2) != stepExec))
        else $error("step did not return to stepExec within three cycles");

endmodule

bind controlUnit controlUnit_checker checker_i (
    .clk    (clk),
    .rstN   (rstN),
    .regCtrl(regCtrl),
    .memCtrl(memCtrl),
    .step   (step)
);

// File: verilog/controlUnit.sv
module controlUnit #(
    parameter isaPkg::regIdx_t SpLowReg = 4'd14
) (
    input  logic                clk,
    input  logic                rstN,
    input  isaPkg::instr_t      instr,
    input  isaPkg::flags_t      flags,
    output ctrlPkg::regCtrl_t   regCtrl,
    output ctrlPkg::aluCtrl_t   aluCtrl,
    output ctrlPkg::memCtrl_t   memCtrl,
    output ctrlPkg::fetchCtrl_t fetchCtrl
);
    import isaPkg::*;
    import ctrlPkg::*;

    instrClass_t instrClass;
    regIdx_t     destReg;
    regIdx_t     srcReg;
    regIdx_t     pairReg;
    condCode_t   cond;
    aluMode_t    aluMode;
    logic        adjInc;
    logic        adjDec;
    step_t       step;
    logic        taken;    // evaluated branch condition

    instrDecoder decoder_i (
        .instr     (instr),
        .instrClass(instrClass),
        .destReg   (destReg),
        .srcReg    (srcReg),
        .pairReg   (pairReg),
        .cond      (cond),
        .aluMode   (aluMode),
        .adjInc    (adjInc),
        .adjDec    (adjDec)
    );

    stepSequencer sequencer_i (
        .clk       (clk),
        .rstN      (rstN),
        .instrClass(instrClass),
        .cond      (cond),
        .flags     (flags),
        .step      (step),
        .taken     (taken)
    );

    controlWordGen #(
        .SpLowReg(SpLowReg)
    ) wordGen_i (
        .instrClass(instrClass),
        .destReg   (destReg),
        .srcReg    (srcReg),
        .pairReg   (pairReg),
        .aluMode   (aluMode),
        .adjInc    (adjInc),
        .adjDec    (adjDec),
        .step      (step),
        .taken     (taken),
        .regCtrl   (regCtrl),
        .aluCtrl   (aluCtrl),
        .memCtrl   (memCtrl),
        .fetchCtrl (fetchCtrl)
    );

endmodule

// File: verilog/controlWordGen.sv
module controlWordGen #(
    parameter isaPkg::regIdx_t SpLowReg = 4'd14
) (
    input  isaPkg::instrClass_t instrClass,
    input  isaPkg::regIdx_t     destReg,
    input  isaPkg::regIdx_t     srcReg,
    input  isaPkg::regIdx_t     pairReg,
    input  isaPkg::aluMode_t    aluMode,
    input  logic                adjInc,
    input  logic                adjDec,
    input  ctrlPkg::step_t      step,
    input  logic                taken,
    output ctrlPkg::regCtrl_t   regCtrl,
    output ctrlPkg::aluCtrl_t   aluCtrl,
    output ctrlPkg::memCtrl_t   memCtrl,
    output ctrlPkg::fetchCtrl_t fetchCtrl
);
    import isaPkg::*;
    import ctrlPkg::*;

    logic dataPhase;

    assign dataPhase = (step == stepDataWait); // read data is back

    always_comb begin
        // NOP word, the classes below override what they need
        regCtrl.src          = regSrcAlu;
        regCtrl.outBSel      = destReg;
        regCtrl.writeEn      = 1'b0;
        regCtrl.incPair      = 1'b0;
        regCtrl.decPair      = 1'b0;
        aluCtrl.bSel         = aluBReg;
        aluCtrl.mode         = aluMode;
        memCtrl.dataSel      = dataAlu;
        memCtrl.addrSel      = addrPair;
        memCtrl.writeEn      = 1'b0;
        memCtrl.readEn       = 1'b0;
        fetchCtrl.addrSel    = fetchPcOut;
        fetchCtrl.readEn     = 1'b1;
        fetchCtrl.pcWriteEn  = 1'b1;
        fetchCtrl.flagEnable = 1'b0;

        case (instrClass)
            aluImm: begin
                regCtrl.writeEn      = 1'b1;
                aluCtrl.bSel         = aluBImm;
                fetchCtrl.flagEnable = (aluMode != aluPassB); // LDI keeps flags
            end
            aluReg: begin
                regCtrl.outBSel      = srcReg;  // zero field for one-register ops
                regCtrl.writeEn      = 1'b1;
                fetchCtrl.flagEnable = 1'b1;
            end
            ioIn: begin
                regCtrl.src         = regSrcMem;
                regCtrl.writeEn     = dataPhase;
                memCtrl.addrSel     = addrPort;
                memCtrl.readEn      = 1'b1;
                fetchCtrl.readEn    = dataPhase;
                fetchCtrl.pcWriteEn = dataPhase;
            end
            ioOut: begin
                memCtrl.addrSel = addrPort;     // ALU passes the register through
                memCtrl.writeEn = 1'b1;
            end
            pairStore: begin
                regCtrl.outBSel = pairReg;
                regCtrl.incPair = adjInc;
                regCtrl.decPair = adjDec;
                memCtrl.writeEn = 1'b1;
            end
            pairLoad: begin
                regCtrl.src         = regSrcMem;
                regCtrl.outBSel     = pairReg;
                regCtrl.writeEn     = dataPhase;
                regCtrl.incPair     = adjInc & dataPhase; // address held during the read
                regCtrl.decPair     = adjDec & dataPhase;
                memCtrl.readEn      = 1'b1;
                fetchCtrl.readEn    = dataPhase;
                fetchCtrl.pcWriteEn = dataPhase;
            end
            pairInc, pairDec: begin
                regCtrl.outBSel = pairReg;
                regCtrl.incPair = adjInc;
                regCtrl.decPair = adjDec;
            end
            jumpIndirect: begin
                regCtrl.outBSel = pairReg;
                if (taken) begin
                    fetchCtrl.addrSel = fetchPair;
                end
            end
            jump: begin
                if (step == stepJumpTarget) begin
                    fetchCtrl.addrSel = fetchIMem;      // target word is on iMemOut
                end else if (!taken) begin
                    fetchCtrl.addrSel = fetchPcPlusOne; // skip the target word
                end
            end
            call: begin
                regCtrl.outBSel = SpLowReg;
                if (step == stepCallHigh) begin
                    regCtrl.decPair   = 1'b1;
                    memCtrl.dataSel   = dataPcHigh;
                    memCtrl.writeEn   = 1'b1;
                    fetchCtrl.addrSel = fetchIMem;
                end else if (taken) begin
                    regCtrl.decPair     = 1'b1;
                    memCtrl.dataSel     = dataPcLow; // low byte goes first
                    memCtrl.writeEn     = 1'b1;
                    fetchCtrl.pcWriteEn = 1'b0;
                end else begin
                    fetchCtrl.addrSel = fetchPcPlusOne;
                end
            end
            ret: begin
                regCtrl.outBSel = SpLowReg;
                memCtrl.addrSel = addrStackPlusOne;
                if (step == stepRetLoad) begin
                    memCtrl.readEn    = 1'b1;
                    fetchCtrl.addrSel = fetchRetAddr;
                end else if (step == stepRetPop || taken) begin
                    regCtrl.incPair     = 1'b1;  // pop one byte per step
                    memCtrl.readEn      = 1'b1;
                    fetchCtrl.addrSel   = fetchRetAddr;
                    fetchCtrl.readEn    = 1'b0;
                    fetchCtrl.pcWriteEn = 1'b0;
                end
            end
            halt: begin
                fetchCtrl.readEn    = 1'b0;
                fetchCtrl.pcWriteEn = 1'b0;
            end
            default: begin
            end
        endcase
    end

endmodule

// File: verilog/ctrlPkg.sv
package ctrlPkg;

    // sequencing steps of multi-cycle instructions
    typedef enum logic [2:0] {
        stepExec,
        stepDataWait,    // IN and pair load data return
        stepJumpTarget,
        stepCallHigh,
        stepRetPop,
        stepRetLoad
    } step_t;

    typedef enum logic {
        regSrcAlu,
        regSrcMem        // IO or data memory read data
    } regSrcSel_t;

    typedef enum logic {
        aluBReg,
        aluBImm          // 8-bit immediate from instr[11:4]
    } aluBSel_t;

    typedef enum logic [1:0] {
        dataPcHigh,
        dataPcLow,
        dataAlu
    } dataSel_t;

    typedef enum logic [1:0] {
        addrPair,        // {outC, outB}
        addrPort,        // IO port field of the word
        addrStackPlusOne
    } addrSel_t;

    typedef enum logic [2:0] {
        fetchPcPlusOne,
        fetchPcOut,
        fetchIMem,
        fetchPair,
        fetchRetAddr     // return register and popped byte
    } fetchSel_t;

    typedef struct packed {
        regSrcSel_t      src;
        isaPkg::regIdx_t outBSel;
        logic            writeEn;
        logic            incPair;
        logic            decPair;
    } regCtrl_t;

    typedef struct packed {
        aluBSel_t         bSel;
        isaPkg::aluMode_t mode;
    } aluCtrl_t;

    typedef struct packed {
        dataSel_t dataSel;
        addrSel_t addrSel;
        logic     writeEn;
        logic     readEn;
    } memCtrl_t;

    typedef struct packed {
        fetchSel_t addrSel;
        logic      readEn;
        logic      pcWriteEn;
        logic      flagEnable;
    } fetchCtrl_t;

endpackage

// File: verilog/instrDecoder.sv
module instrDecoder (
    input  isaPkg::instr_t      instr,
    output isaPkg::instrClass_t instrClass,
    output isaPkg::regIdx_t     destReg,
    output isaPkg::regIdx_t     srcReg,
    output isaPkg::regIdx_t     pairReg,
    output isaPkg::condCode_t   cond,
    output isaPkg::aluMode_t    aluMode,
    output logic                adjInc,
    output logic                adjDec
);
    import isaPkg::*;

    opcode_t  opField;
    pairIdx_t pairField;

    assign opField   = opcode_t'(instr[7:3]);
    assign pairField = instr[11:9];

    assign destReg = instr[15:12];
    assign srcReg  = instr[11:8];
    assign pairReg = {pairField, 1'b0}; // even register of the pair
    assign cond    = condCode_t'(instr[15:13]);

    always_comb begin
        instrClass = nop;                // anything unmatched
        adjInc     = 1'b0;
        adjDec     = 1'b0;
        if (instr[0] && instr[3:1] != 3'b111) begin
            instrClass = aluImm;
        end else if (instr[2:0] == 3'b010) begin
            instrClass = ioIn;
        end else if (instr[2:0] == 3'b100) begin
            instrClass = ioOut;
        end else if (instr[2:0] == 3'b000) begin
            case (opField) inside
                [opAluFirst:opAluLast]: instrClass = aluReg;
                opStore, opStoreInc, opStoreDec: instrClass = pairStore;
                opLoad, opLoadInc, opLoadDec:    instrClass = pairLoad;
                opPairInc: instrClass = pairInc;
                opPairDec: instrClass = pairDec;
                opJumpInd: instrClass = jumpIndirect;
                opJmp:     instrClass = jump;
                opCall:    instrClass = call;
                opRet:     instrClass = ret;
                opHlt:     instrClass = halt;
                default:   instrClass = nop;
            endcase
            // post-adjust of the pair, shared by store, load and the pair ops
            adjInc = (opField == opStoreInc) || (opField == opLoadInc) ||
                     (opField == opPairInc);
            adjDec = (opField == opStoreDec) || (opField == opLoadDec) ||
                     (opField == opPairDec);
        end
    end

    always_comb begin
        case (instrClass)
            aluImm:              aluMode = {1'b0, instr[3:1]}; // 000 is LDI
            aluReg:              aluMode = instr[6:3];
            pairStore, pairLoad: aluMode = aluPassA;
            default:             aluMode = aluPassB;
        endcase
    end

endmodule

// File: verilog/isaPkg.sv
package isaPkg;

    typedef logic [15:0] instr_t;   // fetched instruction word
    typedef logic [3:0]  regIdx_t;  // one of sixteen registers
    typedef logic [2:0]  pairIdx_t; // even register is twice this value

    // branch condition field, instr[15:13]
    typedef enum logic [2:0] {
        condAlways    = 3'b000,
        condCarry     = 3'b001,
        condNoCarry   = 3'b010,
        condZero      = 3'b011,
        condNonZero   = 3'b100,
        condNeg       = 3'b101,
        condNonNeg    = 3'b110,
        condAlwaysAlt = 3'b111   // second encoding of always
    } condCode_t;

    typedef logic [3:0] aluMode_t;

    localparam aluMode_t aluPassB = 4'b0000;
    localparam aluMode_t aluAnd   = 4'b0001;
    localparam aluMode_t aluPassA = 4'b1101;

    // register-form opcode, instr[7:3] with instr[2:0] == 000
    typedef enum logic [4:0] {
        opAluFirst = {1'b0, aluAnd}, // ALU range starts at AND
        opAluLast  = 5'h0C,
        opStore    = 5'h0D,
        opStoreInc = 5'h0E,
        opStoreDec = 5'h0F,
        opLoad     = 5'h10,
        opLoadInc  = 5'h11,
        opLoadDec  = 5'h12,
        opPairInc  = 5'h13,
        opPairDec  = 5'h14,
        opJumpInd  = 5'h15,
        opJmp      = 5'h16,
        opCall     = 5'h17,
        opRet      = 5'h18,
        opHlt      = 5'h1D
    } opcode_t;

    typedef struct packed {
        logic carry;
        logic zero;
        logic negative;
    } flags_t;

    typedef enum logic [3:0] {
        aluImm, aluReg, ioIn, ioOut,
        pairStore, pairLoad, pairInc, pairDec,
        jumpIndirect, jump, call, ret,
        halt, nop
    } instrClass_t;

endpackage

// File: verilog/stepSequencer.sv
module stepSequencer (
    input  logic                clk,
    input  logic                rstN,
    input  isaPkg::instrClass_t instrClass,
    input  isaPkg::condCode_t   cond,
    input  isaPkg::flags_t      flags,
    output ctrlPkg::step_t      step,
    output logic                taken
);
    import isaPkg::*;
    import ctrlPkg::*;

    step_t stepNext;

    // condition table, shared by jumps, calls and returns
    always_comb begin
        case (cond)
            condCarry:   taken = flags.carry;
            condNoCarry: taken = ~flags.carry;
            condZero:    taken = flags.zero;
            condNonZero: taken = ~flags.zero;
            condNeg:     taken = flags.negative;
            condNonNeg:  taken = ~flags.negative;
            default:     taken = 1'b1;   // both always codes
        endcase
    end

    always_comb begin
        stepNext = stepExec;
        case (step)
            stepExec: begin
                case (instrClass)
                    ioIn, pairLoad: begin
                        stepNext = stepDataWait;
                    end
                    jump: begin
                        if (taken) begin
                            stepNext = stepJumpTarget;
                        end
                    end
                    call: begin
                        if (taken) begin
                            stepNext = stepCallHigh;
                        end
                    end
                    ret: begin
                        if (taken) begin
                            stepNext = stepRetPop;
                        end
                    end
                    default: stepNext = stepExec; // halt holds here too
                endcase
            end
            stepRetPop: stepNext = stepRetLoad;
            default:    stepNext = stepExec;     // last step of every sequence
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            step <= stepExec;
        end else begin
            step <= stepNext;
        end
    end

endmodule

// File: vlog.f
verilog/isaPkg.sv
verilog/ctrlPkg.sv
verilog/instrDecoder.sv
verilog/stepSequencer.sv
verilog/controlWordGen.sv
verilog/controlUnit.sv
verification/controlUnit_checker.sv
verification/controlUnitTb.sv
